// ==== bench/tdd_bus_tasks.svh ====
// bus tasks for the tdd register map testbench
// register write and read with ack timeout, value compare, failure stop

`ifndef TDD_BUS_TASKS_SVH
`define TDD_BUS_TASKS_SVH

  // report the reason and end the run
  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
      stop_on_error("a register value did not match");
    end
  endtask

  // drives a one-cycle request and returns at the falling edge where the ack is seen
  task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    int cycles;
    @(posedge up_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    // any earlier ack has dropped after its single cycle
    @(negedge up_clk);
    check_value("wack_idle", 32'd0, 32'(up_wack));
    @(posedge up_clk);
    up_wreq <= 1'b0;
    cycles  = 0;
    @(negedge up_clk);
    while (!up_wack) begin
      cycles++;
      if (cycles >= ACK_TIMEOUT) begin
        stop_on_error("no write acknowledge arrived within the timeout");
      end
      @(negedge up_clk);
    end
    // ack follows the request by one cycle
    check_value("wack_latency", 32'd1, 32'(cycles + 1));
  endtask

  task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    int cycles;
    @(posedge up_clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    cycles  = 0;
    @(negedge up_clk);
    while (!up_rack) begin
      cycles++;
      if (cycles >= ACK_TIMEOUT) begin
        stop_on_error("no read acknowledge arrived within the timeout");
      end
      @(negedge up_clk);
    end
    check_value("rack_latency", 32'd1, 32'(cycles + 1));
    data = up_rdata;
    // ack and data bus return to zero once the request is gone
    @(negedge up_clk);
    check_value("rack_idle", 32'd0, 32'(up_rack));
    check_value("rdata_idle", 32'd0, up_rdata);
  endtask

`endif

// ==== bench/tdd_regmap_tb.sv ====
// testbench for the tdd register map
// clock, reset, vector file loop, port checks and soft sync pulse check

module tdd_regmap_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tdd_pkg::*;

  localparam int ACK_TIMEOUT = 20;

  logic                         up_clk;
  logic                         up_rstn;
  logic                         up_wreq;
  logic [ADDR_WIDTH-1:0]        up_waddr;
  logic [DATA_WIDTH-1:0]        up_wdata;
  logic                         up_wack;
  logic                         up_rreq;
  logic [ADDR_WIDTH-1:0]        up_raddr;
  logic [DATA_WIDTH-1:0]        up_rdata;
  logic                         up_rack;
  logic [1:0]                   tdd_cstate;
  logic                         tdd_enable;
  logic [CHANNEL_COUNT-1:0]     tdd_channel_en;
  logic [CHANNEL_COUNT-1:0]     tdd_channel_pol;
  logic [BURST_COUNT_WIDTH-1:0] tdd_burst_count;
  logic [REGISTER_WIDTH-1:0]    tdd_startup_delay;
  logic [REGISTER_WIDTH-1:0]    tdd_frame_length;
  logic [REGISTER_WIDTH-1:0]    tdd_channel_on  [CHANNEL_COUNT];
  logic [REGISTER_WIDTH-1:0]    tdd_channel_off [CHANNEL_COUNT];
  logic [SYNC_COUNT_WIDTH-1:0]  tdd_sync_period;
  logic                         tdd_sync_rst;
  logic                         tdd_sync_int;
  logic                         tdd_sync_ext;
  logic                         tdd_sync_soft;

  `include "tdd_bus_tasks.svh"

  tdd_regmap #(
    .ID (32'h0000_ABCD)
  ) u_tdd_regmap (
    .up_clk            (up_clk),
    .up_rstn           (up_rstn),
    .up_wreq           (up_wreq),
    .up_waddr          (up_waddr),
    .up_wdata          (up_wdata),
    .up_wack           (up_wack),
    .up_rreq           (up_rreq),
    .up_raddr          (up_raddr),
    .up_rdata          (up_rdata),
    .up_rack           (up_rack),
    .tdd_cstate        (tdd_cstate),
    .tdd_enable        (tdd_enable),
    .tdd_channel_en    (tdd_channel_en),
    .tdd_channel_pol   (tdd_channel_pol),
    .tdd_burst_count   (tdd_burst_count),
    .tdd_startup_delay (tdd_startup_delay),
    .tdd_frame_length  (tdd_frame_length),
    .tdd_channel_on    (tdd_channel_on),
    .tdd_channel_off   (tdd_channel_off),
    .tdd_sync_period   (tdd_sync_period),
    .tdd_sync_rst      (tdd_sync_rst),
    .tdd_sync_int      (tdd_sync_int),
    .tdd_sync_ext      (tdd_sync_ext),
    .tdd_sync_soft     (tdd_sync_soft)
  );

  // ****************************************
  // output port that mirrors each register
  // ****************************************

  // returns 0 for registers that have no output port
  function automatic bit port_value(input logic [7:0] addr, output logic [31:0] value);
    logic [$clog2(CHANNEL_COUNT)-1:0] ch_idx;
    value  = '0;
    ch_idx = addr[$clog2(CHANNEL_COUNT):1];
    if (addr >= ADDR_TDD_CH_ON && addr < 8'(ADDR_TDD_CH_ON + 2 * CHANNEL_COUNT)) begin
      // odd addresses hold the off time
      value = addr[0] ? tdd_channel_off[ch_idx] : tdd_channel_on[ch_idx];
      return 1'b1;
    end
    case (addr)
      ADDR_TDD_CONTROL: begin
        value = 32'({tdd_sync_soft, tdd_sync_ext, tdd_sync_int, tdd_sync_rst, tdd_enable});
      end
      ADDR_TDD_CH_ENABLE:     value = 32'(tdd_channel_en);
      ADDR_TDD_CH_POLARITY:   value = 32'(tdd_channel_pol);
      ADDR_TDD_BURST_COUNT:   value = tdd_burst_count;
      ADDR_TDD_STARTUP_DELAY: value = tdd_startup_delay;
      ADDR_TDD_FRAME_LENGTH:  value = tdd_frame_length;
      ADDR_TDD_SYNC_CNT_LOW:  value = tdd_sync_period[31:0];
      ADDR_TDD_SYNC_CNT_HIGH: value = tdd_sync_period[63:32];
      default:                return 1'b0;
    endcase
    return 1'b1;
  endfunction

  initial begin
    up_clk = 1'b0;
    forever #50 up_clk = ~up_clk;
  end

  // ****************************************
  // vector file loop
  // ****************************************

  initial begin
    int          fd;
    int          n_fields;
    int          n_ops;
    string       line;
    string       op;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] actual;
    up_rstn    = 1'b0;
    up_wreq    = 1'b0;
    up_waddr   = '0;
    up_wdata   = '0;
    up_rreq    = 1'b0;
    up_raddr   = '0;
    tdd_cstate = 2'd0;
    n_ops      = 0;
    repeat (3) @(posedge up_clk);
    up_rstn <= 1'b1;
    fd = $fopen("bench/tdd_regmap_tests.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the test vector file");
    end
    while (!$feof(fd)) begin
      line     = "";
      n_fields = $fgets(line, fd);
      // skip blank and comment lines
      if (line.len() > 1 && line[0] != "#") begin
        n_fields = $sscanf(line, "%s %s %h %h %h", op, name, addr, data, expected);
        if (n_fields != 5) begin
          stop_on_error({"malformed line in the test vector file: ", line});
        end
        n_ops++;
        if (op == "W") begin
          write_reg(addr[ADDR_WIDTH-1:0], data);
          if (port_value(addr[7:0], actual)) begin
            check_value(name, expected, actual);
          end
        end else if (op == "R") begin
          read_reg(addr[ADDR_WIDTH-1:0], actual);
          check_value(name, expected, actual);
        end else if (op == "S") begin
          @(posedge up_clk);
          tdd_cstate <= data[1:0];
        end else if (op == "P") begin
          // pulse is high in the ack cycle only
          write_reg(addr[ADDR_WIDTH-1:0], data);
          check_value(name, expected, 32'(tdd_sync_soft));
          @(negedge up_clk);
          check_value({name, "_cleared"}, 32'd0, 32'(tdd_sync_soft));
        end else begin
          stop_on_error({"unknown operation in the test vector file: ", op});
        end
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      stop_on_error("the test vector file held no operations");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== bench/tdd_regmap_tests.txt ====
# op name addr data expected, all hex; W checks the output port, S drives tdd_cstate, P soft sync
R version 00 0 00020100
R id 01 0 0000abcd
R identify 03 0 5444444e
R interface 04 0 40202027
R control_reset 10 0 0
R frame_reset 15 0 0
R sync_low_reset 16 0 0
R unmapped 3f 0 0
W scratch 02 12345678 0
R scratch 02 0 12345678
W ch_enable 11 a5 a5
R ch_enable 11 0 a5
W polarity 12 3c 3c
W burst 13 00000010 00000010
R burst 13 0 00000010
W delay 14 00000040 00000040
R delay 14 0 00000040
W frame 15 00000200 00000200
W sync_low 16 89abcdef 89abcdef
W sync_high 17 01234567 01234567
R sync_high 17 0 01234567
W ch0_on 20 00000011 00000011
R ch0_on 20 0 00000011
W ch3_on 26 00000033 00000033
W ch7_off 2f 00000077 00000077
R ch7_off 2f 0 00000077
W control 10 0000000f 00000007
R control 10 0 00000007
W frame_locked 15 00000999 00000200
R frame_locked 15 0 00000200
W pol_locked 12 ff 3c
R pol_locked 12 0 3c
W sync_low_locked 16 ffffffff 89abcdef
R sync_low_locked 16 0 89abcdef
W ch3_on_locked 26 00000099 00000033
R ch3_on_locked 26 0 00000033
W scratch_locked 02 cafef00d 0
R scratch_locked 02 0 cafef00d
W ch_enable_locked 11 5a 5a
R ch_enable_locked 11 0 5a
W control_clear 10 0 0
W frame_unlocked 15 00000300 00000300
P soft_sync 10 10 1
R control_soft 10 0 0
S cstate_0 18 0 0
R status_0 18 0 0
S cstate_1 18 1 0
R status_1 18 0 1
S cstate_2 18 2 0
R status_2 18 0 2
S cstate_3 18 3 0
R status_3 18 0 3

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tdd register map testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tdd_regmap_tb -Mdir obj_dir -o tdd_regmap_sim

./obj_dir/tdd_regmap_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// ==== source/tdd_cfg_if.sv ====
// configuration registers shared between the tdd register blocks
// one writer, a narrow view for the channel bank, a full view for readback

interface tdd_cfg_if;

  import tdd_pkg::*;

  // control word
  logic                         enable;
  logic                         sync_rst;
  logic                         sync_int;
  logic                         sync_ext;
  logic                         sync_soft;

  // timing configuration
  logic [CHANNEL_COUNT-1:0]     channel_en;
  logic [CHANNEL_COUNT-1:0]     channel_pol;
  logic [BURST_COUNT_WIDTH-1:0] burst_count;
  logic [REGISTER_WIDTH-1:0]    startup_delay;
  logic [REGISTER_WIDTH-1:0]    frame_length;
  logic [SYNC_COUNT_WIDTH-1:0]  sync_period;

  logic [DATA_WIDTH-1:0]        scratch;

  modport ctrl (
    output enable, sync_rst, sync_int, sync_ext, sync_soft,
    output channel_en, channel_pol, burst_count, startup_delay, frame_length,
    output sync_period, scratch
  );

  // channel bank only needs the write lock
  modport chan (
    input enable
  );

  modport rb (
    input enable, sync_rst, sync_int, sync_ext, sync_soft,
    input channel_en, channel_pol, burst_count, startup_delay, frame_length,
    input sync_period, scratch
  );

endinterface

// ==== source/tdd_channel_regs.sv ====
// per-channel on and off time registers
// writes are dropped while the controller is enabled

module tdd_channel_regs (
  input  logic                                up_clk,
  input  logic                                up_rstn,
  input  logic                                up_wreq,
  input  logic [tdd_pkg::ADDR_WIDTH-1:0]      up_waddr,
  input  logic [tdd_pkg::DATA_WIDTH-1:0]      up_wdata,
  tdd_cfg_if.chan                             cfg,
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]  channel_on  [tdd_pkg::CHANNEL_COUNT],
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]  channel_off [tdd_pkg::CHANNEL_COUNT]
);

  import tdd_pkg::*;

  logic [7:0] waddr_s;
  logic       wr_open_s;

  assign waddr_s   = up_waddr[7:0];
  assign wr_open_s = up_wreq & ~cfg.enable;

  // ****************************************
  // one on/off pair per channel
  // ****************************************

  genvar i;
  generate
    for (i = 0; i < CHANNEL_COUNT; i++) begin : g_channel
      always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
          channel_on[i]  <= '0;
          channel_off[i] <= '0;
        end else begin
          // on at base + 2i, off right after it
          if (wr_open_s && (waddr_s == 8'(ADDR_TDD_CH_ON + 2 * i))) begin
            channel_on[i] <= up_wdata[REGISTER_WIDTH-1:0];
          end
          if (wr_open_s && (waddr_s == 8'(ADDR_TDD_CH_OFF + 2 * i))) begin
            channel_off[i] <= up_wdata[REGISTER_WIDTH-1:0];
          end
        end
      end
    end
  endgenerate

endmodule

// ==== source/tdd_ctrl_regs.sv ====
// write decode and storage for the tdd control registers
// scratch, control, channel masks, burst, delay, frame length, sync period
// also returns the write acknowledge

module tdd_ctrl_regs (
  input  logic                             up_clk,
  input  logic                             up_rstn,
  input  logic                             up_wreq,
  input  logic [tdd_pkg::ADDR_WIDTH-1:0]   up_waddr,
  input  logic [tdd_pkg::DATA_WIDTH-1:0]   up_wdata,
  output logic                             up_wack,
  tdd_cfg_if.ctrl                          cfg
);

  import tdd_pkg::*;

  logic [7:0]                             waddr_s;
  logic                                   wr_open_s;
  logic [DATA_WIDTH-1:0]                  sync_low;
  logic [SYNC_COUNT_WIDTH-DATA_WIDTH-1:0] sync_high;

  // only the low byte of the address is decoded
  assign waddr_s = up_waddr[7:0];

  // timing registers are frozen while the controller runs
  assign wr_open_s = up_wreq & ~cfg.enable;

  // ****************************************
  // always writable registers
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack       <= 1'b0;
      cfg.scratch   <= '0;
      cfg.enable    <= 1'b0;
      cfg.sync_rst  <= 1'b0;
      cfg.sync_int  <= 1'b0;
      cfg.sync_ext  <= 1'b0;
      cfg.sync_soft <= 1'b0;
      cfg.channel_en <= '0;
    end else begin
      up_wack <= up_wreq;
      if (up_wreq && (waddr_s == ADDR_TDD_SCRATCH)) begin
        cfg.scratch <= up_wdata;
      end
      // soft sync lasts one cycle, any other cycle clears it
      cfg.sync_soft <= 1'b0;
      if (up_wreq && (waddr_s == ADDR_TDD_CONTROL)) begin
        cfg.enable    <= up_wdata[CTRL_ENABLE];
        cfg.sync_rst  <= up_wdata[CTRL_SYNC_RST];
        cfg.sync_int  <= up_wdata[CTRL_SYNC_INT] & SYNC_INTERNAL;
        cfg.sync_ext  <= up_wdata[CTRL_SYNC_EXT] & SYNC_EXTERNAL;
        cfg.sync_soft <= up_wdata[CTRL_SYNC_SOFT];
      end
      if (up_wreq && (waddr_s == ADDR_TDD_CH_ENABLE)) begin
        cfg.channel_en <= up_wdata[CHANNEL_COUNT-1:0];
      end
    end
  end

  // ****************************************
  // locked timing registers
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      cfg.channel_pol   <= '0;
      cfg.burst_count   <= '0;
      cfg.startup_delay <= '0;
      cfg.frame_length  <= '0;
      sync_low          <= '0;
      sync_high         <= '0;
    end else if (wr_open_s) begin
      case (waddr_s)
        ADDR_TDD_CH_POLARITY:   cfg.channel_pol   <= up_wdata[CHANNEL_COUNT-1:0];
        ADDR_TDD_BURST_COUNT:   cfg.burst_count   <= up_wdata[BURST_COUNT_WIDTH-1:0];
        ADDR_TDD_STARTUP_DELAY: cfg.startup_delay <= up_wdata[REGISTER_WIDTH-1:0];
        ADDR_TDD_FRAME_LENGTH:  cfg.frame_length  <= up_wdata[REGISTER_WIDTH-1:0];
        ADDR_TDD_SYNC_CNT_LOW:  sync_low          <= up_wdata;
        ADDR_TDD_SYNC_CNT_HIGH: begin
          sync_high <= up_wdata[SYNC_COUNT_WIDTH-DATA_WIDTH-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // high word above low word
  assign cfg.sync_period = {sync_high, sync_low};

endmodule

// ==== source/tdd_pkg.sv ====
// shared constants for the tdd register map
// widths, feature flags, bus address map and identity words

package tdd_pkg;

  // ****************************************
  // widths and feature flags
  // ****************************************

  // number of timed channels
  localparam int CHANNEL_COUNT     = 8;
  localparam int REGISTER_WIDTH    = 32;
  localparam int BURST_COUNT_WIDTH = 32;
  // sync period spans a low and a high word
  localparam int SYNC_COUNT_WIDTH  = 64;

  localparam bit SYNC_INTERNAL = 1'b1;
  // no external sync input in this build
  localparam bit SYNC_EXTERNAL = 1'b0;

  // ****************************************
  // bus and identity
  // ****************************************

  localparam int ADDR_WIDTH = 14;
  localparam int DATA_WIDTH = 32;

  localparam logic [31:0] PCORE_VERSION = 32'h0002_0100;
  // ascii "TDDN"
  localparam logic [31:0] PCORE_MAGIC   = 32'h5444_444E;

  // ****************************************
  // register addresses, low 8 bits only
  // ****************************************

  localparam logic [7:0] ADDR_TDD_VERSION       = 8'h00;
  localparam logic [7:0] ADDR_TDD_ID            = 8'h01;
  localparam logic [7:0] ADDR_TDD_SCRATCH       = 8'h02;
  localparam logic [7:0] ADDR_TDD_IDENTIFY      = 8'h03;
  localparam logic [7:0] ADDR_TDD_INTERFACE     = 8'h04;
  localparam logic [7:0] ADDR_TDD_CONTROL       = 8'h10;
  localparam logic [7:0] ADDR_TDD_CH_ENABLE     = 8'h11;
  localparam logic [7:0] ADDR_TDD_CH_POLARITY   = 8'h12;
  localparam logic [7:0] ADDR_TDD_BURST_COUNT   = 8'h13;
  localparam logic [7:0] ADDR_TDD_STARTUP_DELAY = 8'h14;
  localparam logic [7:0] ADDR_TDD_FRAME_LENGTH  = 8'h15;
  localparam logic [7:0] ADDR_TDD_SYNC_CNT_LOW  = 8'h16;
  localparam logic [7:0] ADDR_TDD_SYNC_CNT_HIGH = 8'h17;
  localparam logic [7:0] ADDR_TDD_STATUS        = 8'h18;
  // channel i sits at base + 2*i, on and off interleaved
  localparam logic [7:0] ADDR_TDD_CH_ON         = 8'h20;
  localparam logic [7:0] ADDR_TDD_CH_OFF        = 8'h21;

  // control word bit positions
  localparam int CTRL_ENABLE    = 0;
  localparam int CTRL_SYNC_RST  = 1;
  localparam int CTRL_SYNC_INT  = 2;
  localparam int CTRL_SYNC_EXT  = 3;
  localparam int CTRL_SYNC_SOFT = 4;

endpackage

// ==== source/tdd_readback.sv ====
// registered read decode for the tdd register map
// identity words, configuration, status and channel timing readback

module tdd_readback #(
  parameter logic [31:0] ID = 32'h0
) (
  input  logic                                up_clk,
  input  logic                                up_rstn,
  input  logic                                up_rreq,
  input  logic [tdd_pkg::ADDR_WIDTH-1:0]      up_raddr,
  output logic [tdd_pkg::DATA_WIDTH-1:0]      up_rdata,
  output logic                                up_rack,
  tdd_cfg_if.rb                               cfg,
  input  logic [tdd_pkg::REGISTER_WIDTH-1:0]  channel_on  [tdd_pkg::CHANNEL_COUNT],
  input  logic [tdd_pkg::REGISTER_WIDTH-1:0]  channel_off [tdd_pkg::CHANNEL_COUNT],
  input  logic [1:0]                          tdd_cstate
);

  import tdd_pkg::*;

  logic [7:0]            raddr_s;
  logic [DATA_WIDTH-1:0] synth_params_s;
  logic [DATA_WIDTH-1:0] ctrl_word_s;
  logic [DATA_WIDTH-1:0] ch_word_s [CHANNEL_COUNT];
  logic [DATA_WIDTH-1:0] ch_rdata_s;
  logic [DATA_WIDTH-1:0] rdata_s;

  assign raddr_s = up_raddr[7:0];

  // build options, fixed at elaboration
  assign synth_params_s = {1'b0, 7'(SYNC_COUNT_WIDTH),
                           8'(BURST_COUNT_WIDTH),
                           8'(REGISTER_WIDTH),
                           1'b0, 1'(SYNC_EXTERNAL), 1'(SYNC_INTERNAL),
                           5'(CHANNEL_COUNT - 1)};

  assign ctrl_word_s = DATA_WIDTH'({cfg.sync_soft, cfg.sync_ext, cfg.sync_int,
                                    cfg.sync_rst, cfg.enable});

  // ****************************************
  // channel timing words
  // ****************************************

  // each channel yields its word on a hit and zero otherwise
  genvar i;
  generate
    for (i = 0; i < CHANNEL_COUNT; i++) begin : g_ch_read
      assign ch_word_s[i] =
        (raddr_s == 8'(ADDR_TDD_CH_ON + 2 * i))  ? DATA_WIDTH'(channel_on[i])  :
        (raddr_s == 8'(ADDR_TDD_CH_OFF + 2 * i)) ? DATA_WIDTH'(channel_off[i]) : '0;
    end
  endgenerate

  always_comb begin
    ch_rdata_s = '0;
    for (int k = 0; k < CHANNEL_COUNT; k++) begin
      ch_rdata_s = ch_rdata_s | ch_word_s[k];
    end
  end

  always_comb begin
    case (raddr_s)
      ADDR_TDD_VERSION:       rdata_s = PCORE_VERSION;
      ADDR_TDD_ID:            rdata_s = ID;
      ADDR_TDD_SCRATCH:       rdata_s = cfg.scratch;
      ADDR_TDD_IDENTIFY:      rdata_s = PCORE_MAGIC;
      ADDR_TDD_INTERFACE:     rdata_s = synth_params_s;
      ADDR_TDD_CONTROL:       rdata_s = ctrl_word_s;
      ADDR_TDD_CH_ENABLE:     rdata_s = DATA_WIDTH'(cfg.channel_en);
      ADDR_TDD_CH_POLARITY:   rdata_s = DATA_WIDTH'(cfg.channel_pol);
      ADDR_TDD_BURST_COUNT:   rdata_s = DATA_WIDTH'(cfg.burst_count);
      ADDR_TDD_STARTUP_DELAY: rdata_s = DATA_WIDTH'(cfg.startup_delay);
      ADDR_TDD_FRAME_LENGTH:  rdata_s = DATA_WIDTH'(cfg.frame_length);
      ADDR_TDD_SYNC_CNT_LOW:  rdata_s = cfg.sync_period[DATA_WIDTH-1:0];
      ADDR_TDD_SYNC_CNT_HIGH: rdata_s = cfg.sync_period[SYNC_COUNT_WIDTH-1:DATA_WIDTH];
      ADDR_TDD_STATUS:        rdata_s = DATA_WIDTH'(tdd_cstate);
      // channel addresses, or zero when nothing matches
      default:                rdata_s = ch_rdata_s;
    endcase
  end

  // ****************************************
  // read response
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      // data bus idles at zero between reads
      up_rdata <= up_rreq ? rdata_s : '0;
    end
  end

endmodule

// ==== source/tdd_regmap.sv ====
// top level of the tdd processor register map
// write side, channel bank and readback joined by the configuration interface

module tdd_regmap #(
  parameter logic [31:0] ID = 32'h0
) (
  input  logic                                   up_clk,
  input  logic                                   up_rstn,

  // processor write bus
  input  logic                                   up_wreq,
  input  logic [tdd_pkg::ADDR_WIDTH-1:0]         up_waddr,
  input  logic [tdd_pkg::DATA_WIDTH-1:0]         up_wdata,
  output logic                                   up_wack,

  // processor read bus
  input  logic                                   up_rreq,
  input  logic [tdd_pkg::ADDR_WIDTH-1:0]         up_raddr,
  output logic [tdd_pkg::DATA_WIDTH-1:0]         up_rdata,
  output logic                                   up_rack,

  // controller state and configuration
  input  logic [1:0]                             tdd_cstate,
  output logic                                   tdd_enable,
  output logic [tdd_pkg::CHANNEL_COUNT-1:0]      tdd_channel_en,
  output logic [tdd_pkg::CHANNEL_COUNT-1:0]      tdd_channel_pol,
  output logic [tdd_pkg::BURST_COUNT_WIDTH-1:0]  tdd_burst_count,
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]     tdd_startup_delay,
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]     tdd_frame_length,
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]     tdd_channel_on  [tdd_pkg::CHANNEL_COUNT],
  output logic [tdd_pkg::REGISTER_WIDTH-1:0]     tdd_channel_off [tdd_pkg::CHANNEL_COUNT],
  output logic [tdd_pkg::SYNC_COUNT_WIDTH-1:0]   tdd_sync_period,
  output logic                                   tdd_sync_rst,
  output logic                                   tdd_sync_int,
  output logic                                   tdd_sync_ext,
  output logic                                   tdd_sync_soft
);

  tdd_cfg_if u_cfg ();

  tdd_ctrl_regs u_tdd_ctrl_regs (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .cfg      (u_cfg.ctrl)
  );

  // channel arrays feed the output ports and readback directly
  tdd_channel_regs u_tdd_channel_regs (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .cfg         (u_cfg.chan),
    .channel_on  (tdd_channel_on),
    .channel_off (tdd_channel_off)
  );

  tdd_readback #(
    .ID (ID)
  ) u_tdd_readback (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .cfg         (u_cfg.rb),
    .channel_on  (tdd_channel_on),
    .channel_off (tdd_channel_off),
    .tdd_cstate  (tdd_cstate)
  );

  // configuration outputs come straight from the registers
  assign tdd_enable        = u_cfg.enable;
  assign tdd_sync_rst      = u_cfg.sync_rst;
  assign tdd_sync_int      = u_cfg.sync_int;
  assign tdd_sync_ext      = u_cfg.sync_ext;
  assign tdd_sync_soft     = u_cfg.sync_soft;
  assign tdd_channel_en    = u_cfg.channel_en;
  assign tdd_channel_pol   = u_cfg.channel_pol;
  assign tdd_burst_count   = u_cfg.burst_count;
  assign tdd_startup_delay = u_cfg.startup_delay;
  assign tdd_frame_length  = u_cfg.frame_length;
  assign tdd_sync_period   = u_cfg.sync_period;

endmodule

// ==== vlog.f ====
+incdir+bench
source/tdd_pkg.sv
source/tdd_cfg_if.sv
source/tdd_ctrl_regs.sv
source/tdd_channel_regs.sv
source/tdd_readback.sv
source/tdd_regmap.sv
bench/tdd_regmap_tb.sv
